// File: hw/mips_mem_pkg.sv
package mips_mem_pkg;

    // Datapath sizes for the MEM stage.
    localparam int DATA_W     = 32;  // Data and address width.
    localparam int NUM_LANES  = 4;   // Byte lanes per word.
    localparam int LANE_W     = 8;   // One byte per lane.
    localparam int OFF_W      = 2;   // Byte offset bits inside a word.
    localparam int DEPTH_LOG2 = 8;   // Word address bits, addr[9:2].
    localparam int DEPTH      = 1 << DEPTH_LOG2;  // 256 words.

    // Pass-through field widths.
    localparam int REG_W      = 5;   // Register file index.
    localparam int WB_CTL_W   = 8;   // Write-back control byte.

    // Memory opcode from the EX stage.
    // Loads come first, then stores.
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,  // No memory access, ALU pass only.
        MEM_LB   = 4'd1,  // Load byte, sign extended.
        MEM_LBU  = 4'd2,  // Load byte, zero extended.
        MEM_LH   = 4'd3,  // Load halfword, sign extended.
        MEM_LHU  = 4'd4,  // Load halfword, zero extended.
        MEM_LW   = 4'd5,  // Load word.
        MEM_SB   = 4'd6,  // Store byte.
        MEM_SH   = 4'd7,  // Store halfword.
        MEM_SW   = 4'd8   // Store word.
    } mem_op_e;

    // Lane masks for partial stores.
    // Lane 0 is the least significant byte.
    //
    // Byte:  one lane at offset 0..3.
    // Half:  lanes 1:0 or 3:2.
    // Word:  all four lanes.
    //
    // Misaligned accesses:
    //   halfword at odd offset,
    //   word at nonzero offset.
    // These never touch the array.
    //
    // Address bits above addr[9] are ignored,
    // the array wraps every 1 KB.
    //
    // Read data comes back one cycle after issue.

endpackage

// File: hw/mem_store_align.sv
`timescale 1ns/1ps

module mem_store_align (
    input  mips_mem_pkg::mem_op_e                i_mem_op,
    input  logic [mips_mem_pkg::OFF_W-1:0]      i_byte_off,
    input  logic [mips_mem_pkg::DATA_W-1:0]     i_wdata,
    output logic [mips_mem_pkg::NUM_LANES-1:0]  o_lane_en,
    output logic [mips_mem_pkg::NUM_LANES-1:0]  o_lane_we,
    output logic [mips_mem_pkg::DATA_W-1:0]     o_lane_wdata,
    output logic                                o_misaligned
);
    import mips_mem_pkg::*;

    logic                 is_load;    // Any load opcode.
    logic                 is_store;   // Any store opcode.
    logic                 size_byte;
    logic                 size_half;
    logic                 size_word;
    logic [NUM_LANES-1:0] lane_mask;  // Lanes touched by the access.

    // Opcode decode.
    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        size_byte = 1'b0;
        size_half = 1'b0;
        size_word = 1'b0;
        case (i_mem_op)
            MEM_LB, MEM_LBU: begin
                is_load   = 1'b1;
                size_byte = 1'b1;
            end
            MEM_LH, MEM_LHU: begin
                is_load   = 1'b1;
                size_half = 1'b1;
            end
            MEM_LW: begin
                is_load   = 1'b1;
                size_word = 1'b1;
            end
            MEM_SB: begin
                is_store  = 1'b1;
                size_byte = 1'b1;
            end
            MEM_SH: begin
                is_store  = 1'b1;
                size_half = 1'b1;
            end
            MEM_SW: begin
                is_store  = 1'b1;
                size_word = 1'b1;
            end
            default: ;                                // MEM_NONE.
        endcase
    end

    // Odd halfword or unaligned word.
    assign o_misaligned = (size_half & i_byte_off[0]) | (size_word & (|i_byte_off));

    // Lanes selected by size and offset.
    always_comb begin
        lane_mask = '0;
        if (size_byte)
            lane_mask = 4'b0001 << i_byte_off;
        else if (size_half)
            lane_mask = i_byte_off[1] ? 4'b1100 : 4'b0011;
        else if (size_word)
            lane_mask = 4'b1111;
    end

    // Loads read the whole word, the extractor picks the bytes.
    assign o_lane_en = o_misaligned ? '0 :
                       is_load      ? '1 :
                       is_store     ? lane_mask : '0;
    assign o_lane_we = (is_store && !o_misaligned) ? lane_mask : '0;

    // Replicate so every enabled lane sees its own byte.
    always_comb begin
        if (size_byte)
            o_lane_wdata = {NUM_LANES{i_wdata[LANE_W-1:0]}};
        else if (size_half)
            o_lane_wdata = {2{i_wdata[2*LANE_W-1:0]}};
        else
            o_lane_wdata = i_wdata;                   // Word or idle.
    end

    // A written lane holds the store byte that belongs to its address.
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            if (o_lane_we[k]) begin
                assert (o_lane_wdata[k*LANE_W +: LANE_W] ==
                        i_wdata[2'(k - i_byte_off)*LANE_W +: LANE_W])
                    else $error("store_align: lane %0d got %h", k,
                                o_lane_wdata[k*LANE_W +: LANE_W]);
            end
        end
    end

endmodule

// File: hw/mem_byte_lane.sv
`timescale 1ns/1ps

module mem_byte_lane (
    input  logic                                i_clk,
    input  logic                                i_en,
    input  logic                                i_we,
    input  logic [mips_mem_pkg::DEPTH_LOG2-1:0] i_addr,
    input  logic [mips_mem_pkg::LANE_W-1:0]     i_wdata,
    output logic [mips_mem_pkg::LANE_W-1:0]     o_rdata
);
    import mips_mem_pkg::*;

    // One byte of every word.
    logic [LANE_W-1:0] mem [0:DEPTH-1];

    // Read-first port.
    // Output holds while the lane is idle.
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_rdata <= mem[i_addr];        // Old data on a same-address write.
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end
        end
    end

    // Write strobe only together with the lane enable.
    a_we_needs_en: assert property (@(posedge i_clk) i_we |-> i_en)
        else $error("byte_lane: write without enable at addr %h", i_addr);

endmodule

// File: hw/mem_load_extract.sv
`timescale 1ns/1ps

module mem_load_extract (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  mips_mem_pkg::mem_op_e           i_mem_op,
    input  logic [mips_mem_pkg::OFF_W-1:0]  i_byte_off,
    input  logic                            i_misaligned,
    input  logic [mips_mem_pkg::DATA_W-1:0] i_lane_rdata,
    output logic [mips_mem_pkg::DATA_W-1:0] o_mem_data,
    output logic                            o_fault
);
    import mips_mem_pkg::*;

    mem_op_e              op_q;       // Opcode aligned with lane data.
    logic [OFF_W-1:0]     off_q;      // Byte offset, same cycle.
    logic                 fault_q;    // Misaligned, same cycle.
    logic [LANE_W-1:0]    byte_sel;
    logic [2*LANE_W-1:0]  half_sel;

    // Issue-cycle controls, delayed to match the RAM read.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            op_q    <= MEM_NONE;
            off_q   <= '0;
            fault_q <= 1'b0;
        end else begin
            op_q    <= i_mem_op;
            off_q   <= i_byte_off;
            fault_q <= i_misaligned;
        end
    end

    assign o_fault = fault_q;

    // Addressed byte and halfword.
    assign byte_sel = i_lane_rdata[off_q*LANE_W +: LANE_W];
    assign half_sel = off_q[1] ? i_lane_rdata[DATA_W-1:2*LANE_W]
                               : i_lane_rdata[2*LANE_W-1:0];

    // Extension per opcode.
    always_comb begin
        o_mem_data = '0;                              // Stores and idle.
        if (!fault_q) begin
            case (op_q)
                MEM_LB:  o_mem_data = {{(DATA_W-LANE_W){byte_sel[LANE_W-1]}}, byte_sel};
                MEM_LBU: o_mem_data = {{(DATA_W-LANE_W){1'b0}}, byte_sel};
                MEM_LH:  o_mem_data = {{(DATA_W-2*LANE_W){half_sel[2*LANE_W-1]}}, half_sel};
                MEM_LHU: o_mem_data = {{(DATA_W-2*LANE_W){1'b0}}, half_sel};
                MEM_LW:  o_mem_data = i_lane_rdata;
                default: o_mem_data = '0;
            endcase
        end
        // A faulted load returns zero.
    end

    // An idle slot never reports a fault one cycle later.
    a_no_fault_idle: assert property (
        @(posedge i_clk) disable iff (i_rst)
        ($past(i_mem_op) == MEM_NONE) |-> !o_fault
    ) else $error("load_extract: fault on idle slot");

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                              i_clk,
    input  logic                              i_rst,

    // From EX/MEM.
    input  mips_mem_pkg::mem_op_e             i_mem_op,
    input  logic [mips_mem_pkg::DATA_W-1:0]   i_addr,     // ALU result.
    input  logic [mips_mem_pkg::DATA_W-1:0]   i_wdata,    // Store data, rt.
    input  logic [mips_mem_pkg::REG_W-1:0]    i_reg_dst,
    input  logic [mips_mem_pkg::WB_CTL_W-1:0] i_wb_ctl,

    // To WB.
    output logic [mips_mem_pkg::DATA_W-1:0]   o_mem_data, // Extended load data.
    output logic [mips_mem_pkg::DATA_W-1:0]   o_alu_data,
    output logic [mips_mem_pkg::REG_W-1:0]    o_reg_dst,
    output logic [mips_mem_pkg::WB_CTL_W-1:0] o_wb_ctl,
    output logic                              o_fault     // Misaligned access.
);
    import mips_mem_pkg::*;

    logic [OFF_W-1:0]      byte_off;    // addr[1:0].
    logic [DEPTH_LOG2-1:0] word_addr;   // addr[9:2].
    logic [NUM_LANES-1:0]  lane_en;
    logic [NUM_LANES-1:0]  lane_we;
    logic [DATA_W-1:0]     lane_wdata;  // Steered store data.
    logic [DATA_W-1:0]     lane_rdata;  // Raw word, one cycle later.
    logic                  misaligned;

    // Address split, upper bits ignored.
    assign byte_off  = i_addr[OFF_W-1:0];
    assign word_addr = i_addr[DEPTH_LOG2+OFF_W-1:OFF_W];

    // Store steering and lane enables.
    mem_store_align inst_store_align (
        .i_mem_op     (i_mem_op),
        .i_byte_off   (byte_off),
        .i_wdata      (i_wdata),
        .o_lane_en    (lane_en),
        .o_lane_we    (lane_we),
        .o_lane_wdata (lane_wdata),
        .o_misaligned (misaligned)
    );

    // Four byte lanes, lane 0 is the LSB.
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        mem_byte_lane inst_byte_lane (
            .i_clk   (i_clk),
            .i_en    (lane_en[k]),
            .i_we    (lane_we[k]),
            .i_addr  (word_addr),                          // Same word for all.
            .i_wdata (lane_wdata[k*LANE_W +: LANE_W]),
            .o_rdata (lane_rdata[k*LANE_W +: LANE_W])
        );
    end

    // Load select and extend.
    mem_load_extract inst_load_extract (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_mem_op     (i_mem_op),
        .i_byte_off   (byte_off),
        .i_misaligned (misaligned),
        .i_lane_rdata (lane_rdata),
        .o_mem_data   (o_mem_data),
        .o_fault      (o_fault)
    );

    // MEM/WB register for the pass-through fields.
    // Lines up with the RAM read latency.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_alu_data <= '0;
            o_reg_dst  <= '0;
            o_wb_ctl   <= '0;
        end else begin
            o_alu_data <= i_addr;       // Address or plain ALU result.
            o_reg_dst  <= i_reg_dst;
            o_wb_ctl   <= i_wb_ctl;
        end
    end

    // EX must always present a defined opcode.
    a_op_known: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !$isunknown(i_mem_op)
    ) else $error("mem_stage: unknown opcode %h", i_mem_op);

endmodule

// File: sim/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import mips_mem_pkg::*;

    localparam int CLK_PERIOD = 4;     // ns.
    localparam int RST_CYCLES = 5;
    // Upper bound on issued operations over all tests.
    localparam int OP_BUDGET  = 256 + 64 + 128 + 208 + 208 + 800;
    localparam int MARGIN     = 200;   // Reset, idle gaps, drain.

    // Expected outputs for one issued operation.
    typedef struct packed {
        int                  cyc;      // Cycle in which it was issued.
        logic [DATA_W-1:0]   data;
        logic                fault;
        logic [DATA_W-1:0]   alu;
        logic [REG_W-1:0]    reg_dst;
        logic [WB_CTL_W-1:0] wb;
    } expect_t;

    logic                clk = 1'b0;
    logic                rst;
    mem_op_e             op_in;
    logic [DATA_W-1:0]   addr_in;
    logic [DATA_W-1:0]   wdata_in;
    logic [REG_W-1:0]    reg_dst_in;
    logic [WB_CTL_W-1:0] wb_ctl_in;
    logic [DATA_W-1:0]   mem_data;
    logic [DATA_W-1:0]   alu_data;
    logic [REG_W-1:0]    reg_dst_out;
    logic [WB_CTL_W-1:0] wb_ctl_out;
    logic                fault;

    logic [LANE_W-1:0]   model_mem [0:1023];  // Byte model, addr[9:0].
    expect_t             exp_q [$];
    integer              seed = 32'h1cf335d2;
    int                  cycle = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  err_at_start = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    mem_stage i_dut (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_mem_op   (op_in),
        .i_addr     (addr_in),
        .i_wdata    (wdata_in),
        .i_reg_dst  (reg_dst_in),
        .i_wb_ctl   (wb_ctl_in),
        .o_mem_data (mem_data),
        .o_alu_data (alu_data),
        .o_reg_dst  (reg_dst_out),
        .o_wb_ctl   (wb_ctl_out),
        .o_fault    (fault)
    );

    // Odd halfword or word off a 4-byte boundary.
    function automatic logic ref_misaligned(input mem_op_e op, input logic [31:0] addr);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: return addr[0];
            MEM_LW, MEM_SW:          return addr[1:0] != 2'b00;
            default:                 return 1'b0;
        endcase
    endfunction

    // Expected load result from the byte model, little-endian.
    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] addr);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        a = addr[9:0];
        b = model_mem[a];
        h = {model_mem[{a[9:1], 1'b1}], model_mem[{a[9:1], 1'b0}]};
        w = {model_mem[{a[9:2], 2'd3}], model_mem[{a[9:2], 2'd2}],
             model_mem[{a[9:2], 2'd1}], model_mem[{a[9:2], 2'd0}]};
        if (ref_misaligned(op, addr))
            return 32'h0;                            // Blocked access.
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            MEM_LW:  return w;
            default: return 32'h0;                   // Stores and idle.
        endcase
    endfunction

    // Model write, skipped for a misaligned store.
    task automatic update_model(input mem_op_e op, input logic [31:0] addr,
                                input logic [31:0] wdata);
        logic [9:0] a;
        a = addr[9:0];
        if (!ref_misaligned(op, addr)) begin
            case (op)
                MEM_SB: model_mem[a] = wdata[7:0];
                MEM_SH: begin
                    model_mem[{a[9:1], 1'b0}] = wdata[7:0];
                    model_mem[{a[9:1], 1'b1}] = wdata[15:8];
                end
                MEM_SW: begin
                    model_mem[{a[9:2], 2'd0}] = wdata[7:0];
                    model_mem[{a[9:2], 2'd1}] = wdata[15:8];
                    model_mem[{a[9:2], 2'd2}] = wdata[23:16];
                    model_mem[{a[9:2], 2'd3}] = wdata[31:24];
                end
                default: ;
            endcase
        end
    endtask

    // Random upper bits, they must not matter.
    function automatic logic [31:0] rand_addr(input logic [7:0] w, input logic [1:0] off);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:10], w, off};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %0s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_zero_outputs();
        check_value("o_mem_data", mem_data, 32'h0);
        check_value("o_alu_data", alu_data, 32'h0);
        check_value("o_reg_dst", 32'(reg_dst_out), 32'h0);
        check_value("o_wb_ctl", 32'(wb_ctl_out), 32'h0);
        check_value("o_fault", 32'(fault), 32'h0);
    endtask

    // Drive one operation on the falling edge and queue its expected outputs.
    task automatic issue(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
        expect_t e;
        @(negedge clk);
        op_in      = op;
        addr_in    = addr;
        wdata_in   = wdata;
        reg_dst_in = 5'($random(seed));
        wb_ctl_in  = 8'($random(seed));
        e.cyc      = cycle;                          // Sampled at the next edge.
        e.data     = ref_load(op, addr);             // Model before this store.
        e.fault    = ref_misaligned(op, addr);
        e.alu      = addr;
        e.reg_dst  = reg_dst_in;
        e.wb       = wb_ctl_in;
        exp_q.push_back(e);
        update_model(op, addr, wdata);
    endtask

    task automatic begin_test();
        err_at_start = errors;
    endtask

    // Idle the stage, let the last result drain, report.
    task automatic end_test(input string name);
        @(negedge clk);
        op_in    = MEM_NONE;
        wdata_in = '0;
        @(posedge clk);
        @(posedge clk);
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %0s: ok", name);
        end else begin
            $display("test %0s: %0d mismatches", name, errors - err_at_start);
            tests_failed++;
        end
    endtask

    // Outputs are stable at the falling edge. Entries from earlier cycles are due.
    always @(negedge clk) begin : compare
        expect_t cur;
        while (exp_q.size() > 0 && exp_q[0].cyc < cycle) begin
            cur = exp_q.pop_front();
            check_value("o_mem_data", mem_data, cur.data);
            check_value("o_fault", 32'(fault), 32'(cur.fault));
            check_value("o_alu_data", alu_data, cur.alu);
            check_value("o_reg_dst", 32'(reg_dst_out), 32'(cur.reg_dst));
            check_value("o_wb_ctl", 32'(wb_ctl_out), 32'(cur.wb));
        end
    end

    // Run limit from the operation budget.
    initial begin : watchdog
        #(CLK_PERIOD * (OP_BUDGET + MARGIN));
        $display("Timeout: the tests did not finish within %0d cycles", OP_BUDGET + MARGIN);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        int          i;
        int          o;
        logic [7:0]  w;
        logic [31:0] d;
        mem_op_e     op;
        mem_op_e     lop;

        rst        = 1'b1;
        op_in      = MEM_NONE;
        addr_in    = '0;
        wdata_in   = '0;
        reg_dst_in = '0;
        wb_ctl_in  = '0;

        // 1. Outputs are zero from the first reset edge on.
        begin_test();
        repeat (RST_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check_zero_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_zero_outputs();                        // Idle cycle after release.
        end_test("reset");

        // 2. Preload every word, then store and load back.
        begin_test();
        for (i = 0; i < 256; i++)
            issue(MEM_SW, rand_addr(8'(i), 2'd0), $random(seed));
        for (i = 0; i < 32; i++) begin
            w = 8'($random(seed));
            issue(MEM_SW, rand_addr(w, 2'd0), $random(seed));
            issue(MEM_LW, rand_addr(w, 2'd0), 32'h0);
        end
        end_test("word_round_trip");

        // 3. Byte and halfword stores, then the whole word.
        begin_test();
        for (i = 0; i < 32; i++) begin
            w = 8'($random(seed));
            issue(MEM_SB, rand_addr(w, 2'($random(seed))), $random(seed));
            issue(MEM_LW, rand_addr(w, 2'd0), 32'h0);
            d = $random(seed);
            issue(MEM_SH, rand_addr(w, {d[0], 1'b0}), $random(seed));
            issue(MEM_LW, rand_addr(w, 2'd0), 32'h0);
        end
        end_test("partial_stores");

        // 4. Sign and zero extension at every legal offset.
        begin_test();
        for (i = 0; i < 16; i++) begin
            w = 8'($random(seed));
            d = $random(seed);
            d = i[0] ? (d & 32'h7f7f7f7f) : (d | 32'h80008000);  // Both sign cases.
            issue(MEM_SW, rand_addr(w, 2'd0), d);
            for (o = 0; o < 4; o++) begin
                issue(MEM_LB, rand_addr(w, 2'(o)), 32'h0);
                issue(MEM_LBU, rand_addr(w, 2'(o)), 32'h0);
                if (!o[0]) begin
                    issue(MEM_LH, rand_addr(w, 2'(o)), 32'h0);
                    issue(MEM_LHU, rand_addr(w, 2'(o)), 32'h0);
                end
            end
        end
        end_test("load_extension");

        // 5. Illegal offsets fault and leave memory alone.
        begin_test();
        for (i = 0; i < 16; i++) begin
            w = 8'($random(seed));
            for (o = 1; o < 4; o++) begin
                if (o[0]) begin
                    issue(MEM_LH, rand_addr(w, 2'(o)), 32'h0);
                    issue(MEM_LHU, rand_addr(w, 2'(o)), 32'h0);
                    issue(MEM_SH, rand_addr(w, 2'(o)), $random(seed));
                end
                issue(MEM_LW, rand_addr(w, 2'(o)), 32'h0);
                issue(MEM_SW, rand_addr(w, 2'(o)), $random(seed));
            end
            issue(MEM_LW, rand_addr(w, 2'd0), 32'h0);  // Word unchanged.
        end
        end_test("misalignment");

        // 6. Back-to-back random mix over a few words to force reuse.
        begin_test();
        for (i = 0; i < 400; i++) begin
            op = mem_op_e'(4'($unsigned($random(seed)) % 9));
            w  = 8'($unsigned($random(seed)) % 16);
            issue(op, rand_addr(w, 2'($random(seed))), $random(seed));
            d = $random(seed);
            if (op >= MEM_SB && d[0]) begin
                // Load from the word just stored, next cycle.
                lop = mem_op_e'(4'(1 + $unsigned($random(seed)) % 5));
                issue(lop, rand_addr(w, 2'($random(seed))), 32'h0);
            end
        end
        end_test("random_mix");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/mips_mem_pkg.sv
hw/mem_store_align.sv
hw/mem_byte_lane.sv
hw/mem_load_extract.sv
hw/mem_stage.sv
sim/tb_mem_stage.sv

// File: Makefile
# Verilator build for the MEM stage testbench.

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_mem_stage
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

SRCS      := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

# The log decides pass or fail, not the exit code of the binary.
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ok"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
